//--- rtl/rp_pkg.sv
// shared sample, calibration and pin types; all widths assume a 14-bit converter pair
`default_nettype none

package rp_pkg;

  //////////////////////////////
  // data types
  //////////////////////////////

  // pin word 15 down to 2, the two lsb pins are reserved
  typedef logic        [13:0] adc_pins_t;
  // signed stream sample, acquisition and generation
  typedef logic signed [13:0] sample_t;
  // calibration gain, GAIN_FRAC fractional bits
  typedef logic signed [15:0] cal_gain_t;
  // calibration offset, same scale as a sample
  typedef logic signed [13:0] cal_offset_t;
  // inverted offset binary code at the DAC pins
  typedef logic        [13:0] dac_code_t;
  // pdm density, ones per 256 cycles
  typedef logic         [7:0] pdm_level_t;

  //////////////////////////////
  // calibration constants
  //////////////////////////////

  // 16384 is unity gain
  localparam int unsigned GAIN_FRAC = 14;

  // saturation limits
  localparam sample_t SAMPLE_MAX = 14'sd8191;
  localparam sample_t SAMPLE_MIN = -14'sd8192;

  // converter code of a zero sample
  localparam dac_code_t DAC_ZERO_CODE = 14'h1fff;

endpackage : rp_pkg

`default_nettype wire

//--- rtl/adc_frontend.sv
// pin capture has no reset, so adc_raw_o is undefined until the first adc_clk edge
`default_nettype none

module adc_frontend (
  input  logic            adc_clk,
  input  logic            top_rst,
  // converter pins
  input  rp_pkg::adc_pins_t adc_dat_i,
  // digital loopback
  input  logic            loop_i,
  input  rp_pkg::sample_t loop_dat_i,
  // sample towards calibration
  output rp_pkg::sample_t adc_raw_o
);

  //////////////////////////////
  // pin capture
  //////////////////////////////

  // converted pin word
  rp_pkg::sample_t pin_dat_q;

  // input block register
  // msb kept, lower 13 inverted gives two's complement
  always_ff @(posedge adc_clk) begin
    pin_dat_q <= {adc_dat_i[13], ~adc_dat_i[12:0]};
  end

  //////////////////////////////
  // loopback mux
  //////////////////////////////

  // calibrated generator sample replaces the converter,
  // no register on this leg
  assign adc_raw_o = loop_i ? loop_dat_i : pin_dat_q;

  // generator path must be out of reset and defined
  // whenever it is looped back
  loop_dat_known_a : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    loop_i |-> !$isunknown(loop_dat_i)
  );

endmodule : adc_frontend

`default_nettype wire

//--- rtl/linear_cal.sv
// two cycle latency, gain and offset are sampled together with dat_i, output clamps to 14 bits
`default_nettype none

module linear_cal (
  input  logic                adc_clk,
  input  logic                top_rst,
  // sample input
  input  rp_pkg::sample_t     dat_i,
  // calibration
  input  rp_pkg::cal_gain_t   gain_i,
  input  rp_pkg::cal_offset_t offset_i,
  // calibrated sample
  output rp_pkg::sample_t     dat_o
);

  // full product width
  localparam int unsigned PROD_W = $bits(rp_pkg::sample_t) + $bits(rp_pkg::cal_gain_t);
  // product after fraction removal
  localparam int unsigned SHF_W = PROD_W - rp_pkg::GAIN_FRAC;
  // one bit of headroom for the offset add
  localparam int unsigned SUM_W = SHF_W + 1;

  //////////////////////////////
  // stage 1, multiply
  //////////////////////////////

  logic signed [PROD_W-1:0] mul_q;
  rp_pkg::cal_offset_t      off_q;

  // offset travels with its product
  always_ff @(posedge adc_clk) begin
    mul_q <= PROD_W'(dat_i) * PROD_W'(gain_i);
    off_q <= offset_i;
  end

  //////////////////////////////
  // stage 2, sum and clamp
  //////////////////////////////

  logic signed [PROD_W-1:0] mul_shr;
  logic signed  [SHF_W-1:0] mul_shf;
  logic signed  [SUM_W-1:0] sum_w;
  // guard bit above the headroom
  logic signed    [SUM_W:0] sum_x;
  rp_pkg::sample_t          sat;

  // drop fraction, floor rounding
  assign mul_shr = mul_q >>> rp_pkg::GAIN_FRAC;
  assign mul_shf = mul_shr[SHF_W-1:0];

  assign sum_w = SUM_W'(mul_shf) + SUM_W'(off_q);
  assign sum_x = (SUM_W + 1)'(mul_shf) + (SUM_W + 1)'(off_q);

  always_comb begin
    if (sum_w > SUM_W'(rp_pkg::SAMPLE_MAX)) begin
      sat = rp_pkg::SAMPLE_MAX;
    end else if (sum_w < SUM_W'(rp_pkg::SAMPLE_MIN)) begin
      sat = rp_pkg::SAMPLE_MIN;
    end else begin
      sat = rp_pkg::sample_t'(sum_w);
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dat_o <= '0;
    end else begin
      dat_o <= sat;
    end
  end

  // headroom keeps the true sign, so the clamped
  // result one cycle on has the sign of the wide sum
  sum_sign_a : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !$past(top_rst) |-> (dat_o[13] == $past(sum_x[SUM_W]))
  );

endmodule : linear_cal

`default_nettype wire

//--- rtl/dac_backend.sv
// cal_o after 2 cycles, dac_dat_o after 3; dac_dat_o rests at the zero code in reset
`default_nettype none

module dac_backend (
  input  logic                adc_clk,
  input  logic                top_rst,
  // generator sample
  input  rp_pkg::sample_t     dat_i,
  // calibration
  input  rp_pkg::cal_gain_t   gain_i,
  input  rp_pkg::cal_offset_t offset_i,
  // calibrated sample, also the loopback source
  output rp_pkg::sample_t     cal_o,
  // converter pins
  output rp_pkg::dac_code_t   dac_dat_o
);

  //////////////////////////////
  // calibration
  //////////////////////////////

  linear_cal u_dac_cal (
    .adc_clk  (adc_clk),
    .top_rst  (top_rst),
    .dat_i    (dat_i),
    .gain_i   (gain_i),
    .offset_i (offset_i),
    .dat_o    (cal_o)
  );

  //////////////////////////////
  // output register
  //////////////////////////////

  // sign kept, rest inverted
  // so the converter sees a negative slope offset binary
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= rp_pkg::DAC_ZERO_CODE;
    end else begin
      dac_dat_o <= {cal_o[13], ~cal_o[12:0]};
    end
  end

endmodule : dac_backend

`default_nettype wire

//--- rtl/pdm_gen.sv
// first order pdm with a fixed 8-bit accumulator, full range is always 256 cycles
`default_nettype none

module pdm_gen #(
  parameter int unsigned PDM_CHN = 4
) (
  input  logic                                    adc_clk,
  input  logic                                    top_rst,
  // density per channel
  input  rp_pkg::pdm_level_t [PDM_CHN-1:0]        level_i,
  // one bit outputs
  output logic               [PDM_CHN-1:0]        pdm_o
);

  localparam int unsigned ACC_W = $bits(rp_pkg::pdm_level_t);

  //////////////////////////////
  // accumulators
  //////////////////////////////

  rp_pkg::pdm_level_t lvl_q [PDM_CHN];
  rp_pkg::pdm_level_t acc_q [PDM_CHN];
  // carry in the top bit
  logic   [ACC_W:0]   acc_sum [PDM_CHN];

  always_comb begin
    for (int ch = 0; ch < PDM_CHN; ch++) begin
      acc_sum[ch] = {1'b0, acc_q[ch]} + {1'b0, lvl_q[ch]};
    end
  end

  // level sampled once per cycle, added next cycle
  // carry count over 256 cycles equals the level
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      for (int ch = 0; ch < PDM_CHN; ch++) begin
        lvl_q[ch] <= '0;
        acc_q[ch] <= '0;
      end
      pdm_o <= '0;
    end else begin
      for (int ch = 0; ch < PDM_CHN; ch++) begin
        lvl_q[ch] <= level_i[ch];
        acc_q[ch] <= acc_sum[ch][ACC_W-1:0];
        pdm_o[ch] <= acc_sum[ch][ACC_W];
      end
    end
  end

endmodule : pdm_gen

`default_nettype wire

//--- rtl/edge_debounce.sv
// pin is asynchronous, stable level starts low; pulses come about DEB_LEN+2 cycles after a change
`default_nettype none

module edge_debounce #(
  parameter int unsigned DEB_LEN = 62500
) (
  input  logic adc_clk,
  input  logic top_rst,
  // expansion pin
  input  logic pin_i,
  // edge pulses, one cycle wide
  output logic pos_o,
  output logic neg_o
);

  localparam int unsigned CNT_W = $clog2(DEB_LEN + 1);

  typedef enum logic {
    ST_STABLE,
    ST_COUNT
  } deb_state_t;

  //////////////////////////////
  // synchronizer
  //////////////////////////////

  logic meta_q;
  logic sync_q;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      meta_q <= 1'b0;
      sync_q <= 1'b0;
    end else begin
      meta_q <= pin_i;
      sync_q <= meta_q;
    end
  end

  //////////////////////////////
  // debounce fsm
  //////////////////////////////

  deb_state_t       state_q;
  logic             level_q;
  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state_q <= ST_STABLE;
      level_q <= 1'b0;
      cnt_q   <= '0;
      pos_o   <= 1'b0;
      neg_o   <= 1'b0;
    end else begin
      // pulses last a single cycle
      pos_o <= 1'b0;
      neg_o <= 1'b0;
      case (state_q)
        ST_STABLE: begin
          cnt_q <= '0;
          if (sync_q != level_q) begin
            state_q <= ST_COUNT;
          end
        end
        ST_COUNT: begin
          if (sync_q == level_q) begin
            // glitch, back without a pulse
            state_q <= ST_STABLE;
            cnt_q   <= '0;
          end else if (cnt_q == CNT_W'(DEB_LEN - 1)) begin
            // new level held long enough
            state_q <= ST_STABLE;
            level_q <= sync_q;
            cnt_q   <= '0;
            pos_o   <= sync_q;
            neg_o   <= ~sync_q;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          state_q <= ST_STABLE;
          cnt_q   <= '0;
        end
      endcase
    end
  end

  // opposite edges never coincide
  edge_excl_a : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !(pos_o && neg_o)
  );

endmodule : edge_debounce

`default_nettype wire

//--- rtl/analog_top.sv
// single adc_clk domain, calibration and loopback come straight from ports with no register map
`default_nettype none

module analog_top #(
  parameter int unsigned ANA_CHN = 2,
  parameter int unsigned PDM_CHN = 4,
  parameter int unsigned DEB_LEN = 62500
) (
  input  logic                                    adc_clk,
  input  logic                                    top_rst,
  // ADC pins
  input  rp_pkg::adc_pins_t   [ANA_CHN-1:0]       adc_dat_i,
  // generator samples
  input  rp_pkg::sample_t     [ANA_CHN-1:0]       gen_dat_i,
  // calibration
  input  rp_pkg::cal_gain_t   [ANA_CHN-1:0]       adc_gain_i,
  input  rp_pkg::cal_gain_t   [ANA_CHN-1:0]       dac_gain_i,
  input  rp_pkg::cal_offset_t [ANA_CHN-1:0]       adc_offset_i,
  input  rp_pkg::cal_offset_t [ANA_CHN-1:0]       dac_offset_i,
  // loopback enable
  input  logic                                    digital_loop_i,
  // calibrated acquisition samples
  output rp_pkg::sample_t     [ANA_CHN-1:0]       adc_cal_o,
  // DAC pins, channels side by side
  output rp_pkg::dac_code_t   [ANA_CHN-1:0]       dac_dat_o,
  // PDM outputs
  input  rp_pkg::pdm_level_t  [PDM_CHN-1:0]       pdm_level_i,
  output logic                [PDM_CHN-1:0]       dac_pwm_o,
  // expansion pin triggers
  input  logic                                    exp_i,
  output logic                                    trg_pos_o,
  output logic                                    trg_neg_o
);

  //////////////////////////////
  // analog channels
  //////////////////////////////

  for (genvar i = 0; i < ANA_CHN; i++) begin : g_chn

    // calibrated generator sample
    rp_pkg::sample_t dac_cal;
    // acquisition sample before calibration
    rp_pkg::sample_t adc_raw;

    dac_backend u_dac (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .dat_i     (gen_dat_i[i]),
      .gain_i    (dac_gain_i[i]),
      .offset_i  (dac_offset_i[i]),
      .cal_o     (dac_cal),
      .dac_dat_o (dac_dat_o[i])
    );

    // loopback taps the dac side after calibration
    adc_frontend u_adc (
      .adc_clk    (adc_clk),
      .top_rst    (top_rst),
      .adc_dat_i  (adc_dat_i[i]),
      .loop_i     (digital_loop_i),
      .loop_dat_i (dac_cal),
      .adc_raw_o  (adc_raw)
    );

    linear_cal u_adc_cal (
      .adc_clk  (adc_clk),
      .top_rst  (top_rst),
      .dat_i    (adc_raw),
      .gain_i   (adc_gain_i[i]),
      .offset_i (adc_offset_i[i]),
      .dat_o    (adc_cal_o[i])
    );

  end : g_chn

  //////////////////////////////
  // pdm outputs
  //////////////////////////////

  pdm_gen #(
    .PDM_CHN (PDM_CHN)
  ) u_pdm (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .level_i (pdm_level_i),
    .pdm_o   (dac_pwm_o)
  );

  //////////////////////////////
  // expansion trigger
  //////////////////////////////

  edge_debounce #(
    .DEB_LEN (DEB_LEN)
  ) u_deb (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .pin_i   (exp_i),
    .pos_o   (trg_pos_o),
    .neg_o   (trg_neg_o)
  );

endmodule : analog_top

`default_nettype wire

//--- tests/tb_analog_top.sv
// runs from the project root with DEB_LEN at 16; all inputs change on the falling edge of adc_clk
`default_nettype none

module tb_analog_top;

  localparam int unsigned NCH  = 2;
  localparam int unsigned NPDM = 4;

  logic                           adc_clk;
  logic                           top_rst;
  rp_pkg::adc_pins_t   [NCH-1:0]  adc_dat;
  rp_pkg::sample_t     [NCH-1:0]  gen_dat;
  rp_pkg::cal_gain_t   [NCH-1:0]  adc_gain;
  rp_pkg::cal_gain_t   [NCH-1:0]  dac_gain;
  rp_pkg::cal_offset_t [NCH-1:0]  adc_off;
  rp_pkg::cal_offset_t [NCH-1:0]  dac_off;
  logic                           loop_en;
  rp_pkg::sample_t     [NCH-1:0]  adc_cal;
  rp_pkg::dac_code_t   [NCH-1:0]  dac_dat;
  rp_pkg::pdm_level_t  [NPDM-1:0] pdm_lvl;
  logic                [NPDM-1:0] pwm;
  logic                           exp_pin;
  logic                           trg_pos;
  logic                           trg_neg;

  // expected outputs and the cycle each one falls due
  logic [27:0] adc_exp_q [$];
  int          adc_due_q [$];
  logic [27:0] dac_exp_q [$];
  int          dac_due_q [$];
  int          cyc;
  logic [15:0] lfsr_q;

  analog_top #(
    .ANA_CHN (NCH),
    .PDM_CHN (NPDM),
    .DEB_LEN (16)
  ) u_dut (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_i      (adc_dat),
    .gen_dat_i      (gen_dat),
    .adc_gain_i     (adc_gain),
    .dac_gain_i     (dac_gain),
    .adc_offset_i   (adc_off),
    .dac_offset_i   (dac_off),
    .digital_loop_i (loop_en),
    .adc_cal_o      (adc_cal),
    .dac_dat_o      (dac_dat),
    .pdm_level_i    (pdm_lvl),
    .dac_pwm_o      (pwm),
    .exp_i          (exp_pin),
    .trg_pos_o      (trg_pos),
    .trg_neg_o      (trg_neg)
  );

  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  //////////////////////////////
  // reference models
  //////////////////////////////

  // pin msb kept, lower 13 inverted
  function automatic rp_pkg::sample_t adc_conv(input rp_pkg::adc_pins_t p);
    return rp_pkg::sample_t'(p ^ 14'h1fff);
  endfunction

  // sign kept, lower 13 inverted
  function automatic rp_pkg::dac_code_t dac_conv(input rp_pkg::sample_t s);
    return rp_pkg::dac_code_t'(s) ^ 14'h1fff;
  endfunction

  // product, floor shift, offset, clamp
  function automatic rp_pkg::sample_t cal_model(input rp_pkg::sample_t x,
      input rp_pkg::cal_gain_t g, input rp_pkg::cal_offset_t o);
    longint sum;
    sum = ((longint'(x) * longint'(g)) >>> rp_pkg::GAIN_FRAC) + longint'(o);
    if (sum > longint'(rp_pkg::SAMPLE_MAX)) begin
      return rp_pkg::SAMPLE_MAX;
    end
    if (sum < longint'(rp_pkg::SAMPLE_MIN)) begin
      return rp_pkg::SAMPLE_MIN;
    end
    return rp_pkg::sample_t'(sum);
  endfunction

  // fibonacci lfsr x^16+x^14+x^13+x^11+1, one step per bit
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[14:0], fb};
    end
    return r;
  endfunction

  //////////////////////////////
  // checking and sequencing
  //////////////////////////////

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare(input logic [31:0] got, input logic [31:0] want, input string what);
    if (got !== want) begin
      $display("FAILED at time %0t: %s is %0h, expected %0h", $time, what, got, want);
      stop_run();
    end
  endtask

  // one falling edge, then any expectation that is due
  task automatic step();
    @(negedge adc_clk);
    cyc++;
    if (adc_due_q.size() > 0 && adc_due_q[0] == cyc) begin
      void'(adc_due_q.pop_front());
      compare({4'b0, adc_cal}, {4'b0, adc_exp_q.pop_front()}, "adc_cal_o");
    end
    if (dac_due_q.size() > 0 && dac_due_q[0] == cyc) begin
      void'(dac_due_q.pop_front());
      compare({4'b0, dac_dat}, {4'b0, dac_exp_q.pop_front()}, "dac_dat_o");
    end
  endtask

  // drains both pipelines before calibration or mode changes
  task automatic flush();
    int n;
    n = 0;
    while (adc_due_q.size() + dac_due_q.size() > 0) begin
      if (n == 8) begin
        $display("pipelines did not drain within 8 cycles");
        stop_run();
      end else begin
        step();
        n++;
      end
    end
  endtask

  task automatic set_loop(input logic on);
    if (loop_en != on) begin
      flush();
      loop_en = on;
    end
  endtask

  // pins only reach adc_cal_o with loopback off, 3 cycles
  task automatic drive_pins(input int p0, input int p1);
    logic [27:0] want;
    adc_dat[0] = rp_pkg::adc_pins_t'(p0);
    adc_dat[1] = rp_pkg::adc_pins_t'(p1);
    for (int ch = 0; ch < NCH; ch++) begin
      want[ch*14 +: 14] = cal_model(adc_conv(adc_dat[ch]), adc_gain[ch], adc_off[ch]);
    end
    if (!loop_en) begin
      adc_exp_q.push_back(want);
      adc_due_q.push_back(cyc + 3);
    end
  endtask

  // dac pins after 3 cycles, looped adc_cal_o after 4
  task automatic drive_gen(input rp_pkg::sample_t s0, input rp_pkg::sample_t s1);
    logic [27:0]     dwant;
    logic [27:0]     awant;
    rp_pkg::sample_t dcal;
    gen_dat[0] = s0;
    gen_dat[1] = s1;
    for (int ch = 0; ch < NCH; ch++) begin
      dcal               = cal_model(gen_dat[ch], dac_gain[ch], dac_off[ch]);
      dwant[ch*14 +: 14] = dac_conv(dcal);
      awant[ch*14 +: 14] = cal_model(dcal, adc_gain[ch], adc_off[ch]);
    end
    dac_exp_q.push_back(dwant);
    dac_due_q.push_back(cyc + 3);
    if (loop_en) begin
      adc_exp_q.push_back(awant);
      adc_due_q.push_back(cyc + 4);
    end
  endtask

  task automatic random_gen(input int n);
    flush();
    for (int ch = 0; ch < NCH; ch++) begin
      dac_gain[ch] = take_bits(16);
      dac_off[ch]  = rp_pkg::cal_offset_t'(take_bits(14));
    end
    repeat (n) begin
      step();
      drive_gen(rp_pkg::sample_t'(take_bits(14)), rp_pkg::sample_t'(take_bits(14)));
    end
  endtask

  // ones per 256 cycles must equal the level
  task automatic pdm_count();
    int cnt [NPDM];
    repeat (4) step();
    for (int ch = 0; ch < NPDM; ch++) begin
      cnt[ch] = 0;
    end
    repeat (256) begin
      step();
      for (int ch = 0; ch < NPDM; ch++) begin
        cnt[ch] += int'(pwm[ch]);
      end
    end
    for (int ch = 0; ch < NPDM; ch++) begin
      compare(32'(cnt[ch]), 32'(pdm_lvl[ch]), "dac_pwm_o ones in 256 cycles");
    end
  endtask

  task automatic short_pulse(input int w);
    exp_pin = 1'b1;
    for (int i = 0; i < w + 30; i++) begin
      step();
      if (i == w - 1) begin
        exp_pin = 1'b0;
      end
      compare(32'({trg_pos, trg_neg}), 32'd0, "trigger after a short pin pulse");
    end
  endtask

  task automatic long_level(input logic lvl);
    int   n;
    logic hit;
    exp_pin = lvl;
    n       = 0;
    hit     = 1'b0;
    while (!hit) begin
      if (n == 24) begin
        $display("no trigger pulse within 24 cycles of pin level %0d", lvl);
        stop_run();
      end else begin
        step();
        n++;
        hit = lvl ? trg_pos : trg_neg;
        compare(32'(lvl ? trg_neg : trg_pos), 32'd0, "opposite trigger");
      end
    end
    // exactly one pulse per change
    repeat (30) begin
      step();
      compare(32'({trg_pos, trg_neg}), 32'd0, "trigger after the single pulse");
    end
  endtask

  task automatic run_cmd(input byte cmd, input int op [4]);
    case (cmd)
      "a", "d": begin
        flush();
        for (int ch = 0; ch < NCH; ch++) begin
          if (cmd == "a") begin
            adc_gain[ch] = rp_pkg::cal_gain_t'(op[2*ch]);
            adc_off[ch]  = rp_pkg::cal_offset_t'(op[2*ch+1]);
          end else begin
            dac_gain[ch] = rp_pkg::cal_gain_t'(op[2*ch]);
            dac_off[ch]  = rp_pkg::cal_offset_t'(op[2*ch+1]);
          end
        end
      end
      "x": begin
        set_loop(1'b0);
        step();
        drive_pins(op[0], op[1]);
      end
      "y": begin
        step();
        drive_gen(rp_pkg::sample_t'(op[0]), rp_pkg::sample_t'(op[1]));
      end
      "l": begin
        set_loop(1'b1);
        step();
        drive_pins(op[2], op[3]);
        drive_gen(rp_pkg::sample_t'(op[0]), rp_pkg::sample_t'(op[1]));
      end
      "r": random_gen(op[0]);
      "p": begin
        step();
        for (int ch = 0; ch < NPDM; ch++) begin
          pdm_lvl[ch] = rp_pkg::pdm_level_t'(op[ch]);
        end
        pdm_count();
      end
      "s": short_pulse(op[0]);
      "e": long_level(op[0] != 0);
      default: begin
        $display("unknown command %c in the vector file", cmd);
        stop_run();
      end
    endcase
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int    fd;
    int    rc;
    byte   cmd;
    int    op [4];
    string line;
    top_rst = 1'b1;
    loop_en = 1'b0;
    exp_pin = 1'b0;
    cyc     = 0;
    lfsr_q  = 16'd20;
    pdm_lvl = '0;
    for (int ch = 0; ch < NCH; ch++) begin
      // pin word of a zero sample
      adc_dat[ch]  = 14'h1fff;
      gen_dat[ch]  = '0;
      adc_gain[ch] = 16'sd16384;
      dac_gain[ch] = 16'sd16384;
      adc_off[ch]  = '0;
      dac_off[ch]  = '0;
    end
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    top_rst = 1'b0;
    compare({4'b0, adc_cal}, 32'd0, "adc_cal_o after reset");
    compare({4'b0, dac_dat}, {4'b0, 14'd8191, 14'd8191}, "dac_dat_o after reset");
    compare(32'({pwm, trg_pos, trg_neg}), 32'd0, "pdm and triggers after reset");
    fd = $fopen("tests/analog_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/analog_tests.txt");
      stop_run();
    end else begin
      rc = $fscanf(fd, " %c", cmd);
      while (rc == 1) begin
        if (cmd == "#") begin
          rc = $fgets(line, fd);
        end else begin
          rc = $fscanf(fd, "%d %d %d %d", op[0], op[1], op[2], op[3]);
          if (rc != 4) begin
            $display("malformed operands for command %c in the vector file", cmd);
            stop_run();
          end else begin
            run_cmd(cmd, op);
          end
        end
        rc = $fscanf(fd, " %c", cmd);
      end
      $fclose(fd);
      flush();
      $display("Verification passed");
      $finish;
    end
  end

endmodule : tb_analog_top

`default_nettype wire

//--- tests/analog_tests.txt
# one command letter and four decimal operands per line, unused operands are 0
# a/d: gain0 off0 gain1 off1 | x: pins0 pins1 | y: gen0 gen1 | l: gen0 gen1 pins0 pins1
# r: lfsr vector count | p: pdm levels 0..3 | s: short pulse width | e: long pin level
a 16384 0 16384 0
x 8191 8191 0 0
x 0 16383 0 0
x 8192 4000 0 0
x 12345 100 0 0
a 20000 300 -12000 -500
x 1000 15000 0 0
x 6000 9000 0 0
a 32767 8000 -32768 -8192
x 0 0 0 0
x 16383 16383 0 0
x 2000 12000 0 0
d 16384 0 16384 0
y 0 8191 0 0
y -8192 -1 0 0
d 24000 -700 -20000 8191
y 5000 -6000 0 0
y 8191 -8192 0 0
r 20 0 0 0
a 16384 0 12000 200
l 1234 -4321 0 16383
l 8191 -8192 5555 777
l -100 100 42 42
r 12 0 0 0
p 0 1 128 255
p 17 200 64 3
s 3 0 0 0
s 15 0 0 0
e 1 0 0 0
e 0 0 0 0

//--- filelist.f
rtl/rp_pkg.sv
rtl/adc_frontend.sv
rtl/linear_cal.sv
rtl/dac_backend.sv
rtl/pdm_gen.sv
rtl/edge_debounce.sv
rtl/analog_top.sv
tests/tb_analog_top.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_analog_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_analog_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if grep -qx "Verification passed" "$log"; then
  exit 0
fi
echo "pass message missing from $log"
exit 1
